/* rtl/daisy_pkg.sv */
// ************************************************************
// daisy link shared definitions
// frame layout, word types, tx mode encoding,
// training and idle frames, and the PRBS-16 step
// ************************************************************

package daisy_pkg;

  // frame is flag bit on top of a 16-bit payload
  localparam int FRAME_W = 17;
  localparam int DATA_W  = FRAME_W - 1;
  localparam int CNT_W   = $clog2(FRAME_W); // enough for bit index 0..16

  typedef logic [DATA_W-1:0]  data_word_t;
  typedef logic [FRAME_W-1:0] frame_t;    // [16] flag, 1 = data word
  typedef logic [15:0]        err_cnt_t;  // saturating
  typedef logic [CNT_W-1:0]   bit_cnt_t;

  typedef enum logic [1:0] {
    MODE_USER   = 2'd0, // words from parallel input
    MODE_TRAIN  = 2'd1, // training frames only
    MODE_CUSTOM = 2'd2, // cfg word repeated
    MODE_RANDOM = 2'd3  // lfsr sequence
  } tx_mode_e;

  localparam bit_cnt_t LAST_BIT = bit_cnt_t'(FRAME_W - 1);

  // non-constant 17-bit pattern, so no rotation of it equals itself
  localparam data_word_t TRAIN_WORD  = 16'hF419;
  localparam frame_t     TRAIN_FRAME = {1'b0, TRAIN_WORD};
  localparam data_word_t IDLE_WORD   = '0;
  localparam frame_t     IDLE_FRAME  = {1'b0, IDLE_WORD};  // all zero

  localparam data_word_t LFSR_SEED = 16'hACE1;

  // fibonacci step, taps 16 14 13 11
  function automatic data_word_t lfsr_next(input data_word_t cur);
    return {cur[14:0], cur[15] ^ cur[13] ^ cur[12] ^ cur[10]};
  endfunction

endpackage

/* rtl/daisy_word_src.sv */
// ************************************************************
// daisy tx word source
// picks user, training, custom or lfsr words by mode and
// writes flagged frames into the tx fifo
// ************************************************************

`timescale 1ns/1ps

module daisy_word_src import daisy_pkg::*; (
  input  logic       sys_clk,
  input  logic       par_rstn,
  input  logic       tx_en_i,      // transmitter enable
  input  tx_mode_e   cfg_mode_i,
  input  data_word_t cfg_custom_i,
  input  logic       par_dv_i,     // user word valid
  input  data_word_t par_dat_i,
  input  logic       full_i,       // fifo full
  output logic       par_rdy_o,
  output logic       wr_en_o,
  output frame_t     wr_frame_o
);

  logic       mode_user;
  logic       room;       // a write may be issued this cycle
  logic       take;       // word accepted this cycle
  frame_t     src_frame;
  data_word_t lfsr_q;     // prbs state, next random payload

  assign mode_user = (cfg_mode_i == MODE_USER);

  // only one write outstanding, the full flag
  // then always covers the write already on its way
  assign room = tx_en_i && !full_i && !wr_en_o;

  assign par_rdy_o = mode_user && room;

  // user words need dv, generated words go whenever there is room
  assign take = mode_user ? (par_dv_i && par_rdy_o) : room;

  always_comb begin
    case (cfg_mode_i)
      MODE_USER:   src_frame = {1'b1, par_dat_i};
      MODE_TRAIN:  src_frame = TRAIN_FRAME;     // flag 0
      MODE_CUSTOM: src_frame = {1'b1, cfg_custom_i};
      MODE_RANDOM: src_frame = {1'b1, lfsr_q};
      default:     src_frame = TRAIN_FRAME;
    endcase
  end

  // write strobe and lfsr state
  always_ff @(posedge sys_clk) begin
    if (!par_rstn) begin
      wr_en_o <= 1'b0;
      lfsr_q  <= LFSR_SEED;
    end else begin
      wr_en_o <= take;
      if (take && (cfg_mode_i == MODE_RANDOM)) begin
        lfsr_q <= lfsr_next(lfsr_q); // step per written word
      end
    end
  end

  // frame register, moves together with wr_en_o
  always_ff @(posedge sys_clk) begin
    if (take) begin
      wr_frame_o <= src_frame;
    end
  end

endmodule

/* rtl/daisy_tx_fifo.sv */
// ************************************************************
// daisy tx fifo
// register array fifo for 17-bit frames, wrap-bit pointers,
// registered read data one cycle after rd_en
// ************************************************************

`timescale 1ns/1ps

module daisy_tx_fifo import daisy_pkg::*; #(
  parameter int FIFO_DEPTH = 8  // power of two, 2 or more
) (
  input  logic   sys_clk,
  input  logic   par_rstn,
  input  logic   wr_en_i,
  input  frame_t wr_frame_i,
  input  logic   rd_en_i,
  output frame_t rd_frame_o,
  output logic   full_o,
  output logic   empty_o
);

  localparam int AW = $clog2(FIFO_DEPTH);

  frame_t       mem [FIFO_DEPTH];
  logic [AW:0]  wr_ptr;   // msb is the wrap bit
  logic [AW:0]  rd_ptr;
  logic         do_wr;
  logic         do_rd;

  // same slot, different lap -> full
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty_o = (wr_ptr == rd_ptr);

  assign do_wr = wr_en_i && !full_o;   // writes into a full fifo are dropped
  assign do_rd = rd_en_i && !empty_o;

  // pointers
  always_ff @(posedge sys_clk) begin
    if (!par_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge sys_clk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= wr_frame_i;
    end
  end

  // read port, data valid the cycle after rd_en_i
  always_ff @(posedge sys_clk) begin
    if (do_rd) begin
      rd_frame_o <= mem[rd_ptr[AW-1:0]];
    end
  end

endmodule

/* rtl/daisy_serializer.sv */
// ************************************************************
// daisy serializer
// one frame per 17 clocks, msb (flag) first,
// idle frame whenever the fifo had nothing to give
// ************************************************************

`timescale 1ns/1ps

module daisy_serializer import daisy_pkg::*; (
  input  logic   sys_clk,
  input  logic   par_rstn,
  input  logic   tx_en_i,
  input  logic   empty_i,     // fifo empty
  input  frame_t rd_frame_i,  // fifo read data
  output logic   rd_en_o,
  output logic   ser_dat_o
);

  // fetch two bits before the wrap, data is there one cycle later
  localparam bit_cnt_t FETCH_BIT = bit_cnt_t'(FRAME_W - 2);

  bit_cnt_t bit_cnt;   // bit on the line, 0..16
  logic     rd_pend;   // read issued for the coming frame
  frame_t   shift_q;

  assign rd_en_o = tx_en_i && (bit_cnt == FETCH_BIT) && !empty_i;

  assign ser_dat_o = shift_q[FRAME_W-1];

  always_ff @(posedge sys_clk) begin
    if (!par_rstn) begin
      bit_cnt <= '0;
      rd_pend <= 1'b0;
      shift_q <= '0;
    end else if (!tx_en_i) begin
      // line parked low, next frame starts at bit 0
      bit_cnt <= '0;
      rd_pend <= 1'b0;
      shift_q <= '0;
    end else begin
      if (bit_cnt == FETCH_BIT) begin
        rd_pend <= rd_en_o;
      end
      if (bit_cnt == LAST_BIT) begin
        bit_cnt <= '0;
        rd_pend <= 1'b0;
        // frame boundary, load new word or idle
        shift_q <= rd_pend ? rd_frame_i : IDLE_FRAME;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        shift_q <= {shift_q[FRAME_W-2:0], 1'b0}; // msb first
      end
    end
  end

endmodule

/* rtl/daisy_rx.sv */
// ************************************************************
// daisy receiver
// hunts for the training frame, then cuts the bit stream
// into frames, outputs data words, and counts prbs errors
// ************************************************************

`timescale 1ns/1ps

module daisy_rx import daisy_pkg::*; (
  input  logic       sys_clk,
  input  logic       par_rstn,
  input  logic       rx_en_i,
  input  logic       chk_en_i,     // prbs check enable
  input  logic       err_clr_i,    // clear error count
  input  logic       ser_dat_i,
  output logic       rx_dv_o,
  output data_word_t rx_dat_o,
  output logic       rx_locked_o,
  output err_cnt_t   err_cnt_o
);

  typedef enum logic {
    RX_HUNT,
    RX_LOCKED
  } rx_state_e;

  rx_state_e  state;
  frame_t     win;        // last 17 bits, newest in lsb
  bit_cnt_t   bit_cnt;    // index of the last sampled bit
  logic       frame_done; // win holds a whole data frame
  data_word_t prev_word;  // last received data word
  logic       has_prev;
  logic       prbs_bad;

  assign rx_locked_o = (state == RX_LOCKED);

  assign frame_done = rx_locked_o && (bit_cnt == LAST_BIT) && win[FRAME_W-1];

  assign prbs_bad = has_prev && (win[DATA_W-1:0] != lfsr_next(prev_word));

  // serial input window
  always_ff @(posedge sys_clk) begin
    if (!par_rstn) begin
      win <= '0;
    end else begin
      win <= {win[FRAME_W-2:0], ser_dat_i};
    end
  end

  // alignment fsm and frame bit counter
  always_ff @(posedge sys_clk) begin
    if (!par_rstn) begin
      state   <= RX_HUNT;
      bit_cnt <= '0;
    end else begin
      case (state)
        RX_HUNT: begin
          bit_cnt <= '0;   // bit sampled at the lock edge is bit 0
          if (rx_en_i && (win == TRAIN_FRAME)) begin
            state <= RX_LOCKED;
          end
        end
        RX_LOCKED: begin
          if (!rx_en_i) begin
            state <= RX_HUNT;
          end
          bit_cnt <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
        end
        default: state <= RX_HUNT;
      endcase
    end
  end

  // valid word pulse, one per data frame
  always_ff @(posedge sys_clk) begin
    if (!par_rstn) begin
      rx_dv_o <= 1'b0;
    end else begin
      rx_dv_o <= frame_done;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (frame_done) begin
      rx_dat_o  <= win[DATA_W-1:0];
      prev_word <= win[DATA_W-1:0];   // reference for the next word
    end
  end

  // prbs checker
  always_ff @(posedge sys_clk) begin
    if (!par_rstn) begin
      has_prev  <= 1'b0;
      err_cnt_o <= '0;
    end else begin
      // first word after enable or lock only seeds the check
      if (!chk_en_i || !rx_locked_o) begin
        has_prev <= 1'b0;
      end else if (frame_done) begin
        has_prev <= 1'b1;
      end
      if (err_clr_i) begin
        err_cnt_o <= '0;
      end else if (chk_en_i && frame_done && prbs_bad && (err_cnt_o != '1)) begin
        err_cnt_o <= err_cnt_o + 1'b1;   // saturates at all ones
      end
    end
  end

endmodule

/* rtl/daisy_link.sv */
// ************************************************************
// daisy link top
// word source, tx fifo and serializer on the way out,
// receiver with prbs checker on the way in
// ************************************************************

`timescale 1ns/1ps

module daisy_link import daisy_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic       sys_clk,
  input  logic       par_rstn,
  input  logic       tx_en_i,
  input  logic       rx_en_i,
  input  logic       chk_en_i,
  input  logic       err_clr_i,
  input  tx_mode_e   cfg_mode_i,
  input  data_word_t cfg_custom_i,
  input  logic       par_dv_i,
  input  data_word_t par_dat_i,
  output logic       par_rdy_o,
  output logic       ser_dat_o,    // serial line out
  input  logic       ser_dat_i,    // serial line in
  output logic       rx_dv_o,
  output data_word_t rx_dat_o,
  output logic       rx_locked_o,
  output err_cnt_t   err_cnt_o
);

  logic   wr_en;
  frame_t wr_frame;
  logic   rd_en;
  frame_t rd_frame;
  logic   fifo_full;
  logic   fifo_empty;

  daisy_word_src u_word_src (
    .sys_clk      (sys_clk),
    .par_rstn     (par_rstn),
    .tx_en_i      (tx_en_i),
    .cfg_mode_i   (cfg_mode_i),
    .cfg_custom_i (cfg_custom_i),
    .par_dv_i     (par_dv_i),
    .par_dat_i    (par_dat_i),
    .full_i       (fifo_full),
    .par_rdy_o    (par_rdy_o),
    .wr_en_o      (wr_en),
    .wr_frame_o   (wr_frame)
  );

  daisy_tx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_tx_fifo (
    .sys_clk    (sys_clk),
    .par_rstn   (par_rstn),
    .wr_en_i    (wr_en),
    .wr_frame_i (wr_frame),
    .rd_en_i    (rd_en),
    .rd_frame_o (rd_frame),
    .full_o     (fifo_full),
    .empty_o    (fifo_empty)
  );

  daisy_serializer u_serializer (
    .sys_clk    (sys_clk),
    .par_rstn   (par_rstn),
    .tx_en_i    (tx_en_i),
    .empty_i    (fifo_empty),
    .rd_frame_i (rd_frame),
    .rd_en_o    (rd_en),
    .ser_dat_o  (ser_dat_o)
  );

  // rx side, fed from the line (loopback or far end)
  daisy_rx u_rx (
    .sys_clk     (sys_clk),
    .par_rstn    (par_rstn),
    .rx_en_i     (rx_en_i),
    .chk_en_i    (chk_en_i),
    .err_clr_i   (err_clr_i),
    .ser_dat_i   (ser_dat_i),
    .rx_dv_o     (rx_dv_o),
    .rx_dat_o    (rx_dat_o),
    .rx_locked_o (rx_locked_o),
    .err_cnt_o   (err_cnt_o)
  );

endmodule

/* verif/daisy_link_tb.sv */
// ************************************************************
// daisy link testbench
// serial loopback with delay and bit flips, user / custom /
// random traffic, prbs error counting and error clear
// ************************************************************

`timescale 1ns/1ps

module daisy_link_tb import daisy_pkg::*;;

  localparam int FIFO_DEPTH   = 8;
  localparam int HALF_PERIOD  = 4;          // 8 ns clock
  localparam int LOOP_DELAY   = 5;          // not a multiple of 17
  localparam int N_USER       = 40;
  localparam int N_CUSTOM     = 20;
  localparam int N_RANDOM     = 40;
  localparam int N_FLIP       = 4;
  localparam int N_AFTER      = 20;
  localparam int QUIET_CYCLES = 3 * FRAME_W;
  localparam int BURST_LIMIT  = 400;
  localparam data_word_t SEED_WORD = 16'hACE1;  // first prbs word
  localparam int PLANNED_FRAMES = 7 + N_USER + N_CUSTOM + N_RANDOM + 6 * N_FLIP + N_AFTER
                                  + 4 * (FIFO_DEPTH + 3);
  localparam int WATCHDOG_CYCLES = FRAME_W * (PLANNED_FRAMES + 200);

  typedef enum {MON_NONE, MON_USER, MON_CUSTOM, MON_RANDOM} mon_mode_e;

  logic       sys_clk;
  logic       par_rstn;
  logic       tx_en_i, rx_en_i, chk_en_i, err_clr_i;
  tx_mode_e   cfg_mode_i;
  data_word_t cfg_custom_i;
  logic       par_dv_i;
  data_word_t par_dat_i;
  logic       par_rdy_o, ser_dat_o, ser_dat_i;
  logic       rx_dv_o, rx_locked_o;
  data_word_t rx_dat_o;
  err_cnt_t   err_cnt_o;

  logic [LOOP_DELAY-1:0] loop_q = '0;  // serial loopback delay line
  logic       flip_en;            // invert the bit entering the loop
  integer     seed = 53954;
  data_word_t exp_q[$];           // accepted user words, oldest first
  data_word_t exp_word;           // last expected prbs word
  logic       have_exp;
  mon_mode_e  mon_mode, last_mode;
  int         flips_sent, bad_words;

  daisy_link #(.FIFO_DEPTH(FIFO_DEPTH)) dut (
    .sys_clk(sys_clk), .par_rstn(par_rstn),
    .tx_en_i(tx_en_i), .rx_en_i(rx_en_i), .chk_en_i(chk_en_i), .err_clr_i(err_clr_i),
    .cfg_mode_i(cfg_mode_i), .cfg_custom_i(cfg_custom_i),
    .par_dv_i(par_dv_i), .par_dat_i(par_dat_i), .par_rdy_o(par_rdy_o),
    .ser_dat_o(ser_dat_o), .ser_dat_i(ser_dat_i),
    .rx_dv_o(rx_dv_o), .rx_dat_o(rx_dat_o), .rx_locked_o(rx_locked_o),
    .err_cnt_o(err_cnt_o)
  );

  always #HALF_PERIOD sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    if (!par_rstn) begin
      loop_q <= '0;
    end else begin
      loop_q <= {loop_q[LOOP_DELAY-2:0], ser_dat_o ^ flip_en};
    end
  end
  assign ser_dat_i = loop_q[LOOP_DELAY-1];

  // prbs step, taps at bits 15 13 12 10
  function automatic data_word_t ref_next(input data_word_t w);
    logic fb;
    fb = w[15] ^ w[13] ^ w[12] ^ w[10];
    return {w[14:0], fb};
  endfunction

  function automatic bit single_bit_diff(input data_word_t a, input data_word_t b);
    data_word_t d;
    int ones;
    d = a ^ b;
    ones = 0;
    for (int k = 0; k < 16; k++) begin
      if (d[k]) ones++;
    end
    return ones == 1;
  endfunction

  task automatic end_with_failure();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_cnt(input string name, input err_cnt_t exp, input err_cnt_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      end_with_failure();
    end
  endtask

  // counts rx_dv_o pulses, returns on the negedge of the last one
  task automatic wait_rx(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge sys_clk);
      if (rx_dv_o) seen++;
    end
  endtask

  task automatic wait_quiet();  // no data frame for 3 frame times
    int idle;
    idle = 0;
    while (idle < QUIET_CYCLES) begin
      @(negedge sys_clk);
      idle = rx_dv_o ? 0 : idle + 1;
    end
  endtask

  // response monitor, one compare per rx_dv_o pulse
  always @(negedge sys_clk) begin
    if (mon_mode != last_mode) begin
      have_exp  = 1'b0;  // new phase, prbs reference restarts
      last_mode = mon_mode;
    end
    if (rx_dv_o) begin
      case (mon_mode)
        MON_USER: begin
          if (exp_q.size() == 0) begin
            $display("rx_dv_o pulsed with no accepted user word outstanding");
            end_with_failure();
          end else begin
            check_word("rx_dat_o", exp_q.pop_front(), rx_dat_o);
          end
        end
        MON_CUSTOM: check_word("rx_dat_o", cfg_custom_i, rx_dat_o);
        MON_RANDOM: begin
          if (!have_exp) begin
            exp_word = SEED_WORD;
            have_exp = 1'b1;
          end else begin
            exp_word = ref_next(exp_word);
          end
          if (rx_dat_o !== exp_word && flips_sent > bad_words &&
              single_bit_diff(rx_dat_o, exp_word)) begin
            bad_words++;  // the word hit by an injected flip
          end else begin
            check_word("rx_dat_o", exp_word, rx_dat_o);
          end
        end
        default: begin
          $display("rx_dv_o pulsed while only training or idle frames were sent");
          end_with_failure();
        end
      endcase
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
    $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
    end_with_failure();
  end

  initial begin
    logic [31:0] rnd;
    int low_run;
    int n;
    int accepted;
    int pos;
    sys_clk = 1'b0;
    par_rstn = 1'b0;
    tx_en_i = 1'b0;
    rx_en_i = 1'b0;
    chk_en_i = 1'b0;
    err_clr_i = 1'b0;
    cfg_mode_i = MODE_TRAIN;
    cfg_custom_i = '0;
    par_dv_i = 1'b0;
    par_dat_i = '0;
    flip_en = 1'b0;
    mon_mode = MON_NONE;
    last_mode = MON_NONE;
    have_exp = 1'b0;
    exp_word = '0;
    flips_sent = 0;
    bad_words = 0;
    repeat (4) @(negedge sys_clk);
    par_rstn = 1'b1;
    @(negedge sys_clk);
    check_bit("par_rdy_o", 1'b0, par_rdy_o);
    check_bit("ser_dat_o", 1'b0, ser_dat_o);
    check_bit("rx_dv_o", 1'b0, rx_dv_o);
    check_bit("rx_locked_o", 1'b0, rx_locked_o);
    check_cnt("err_cnt_o", '0, err_cnt_o);

    tx_en_i = 1'b1;  // training, lock within 3 frames plus loop delay
    rx_en_i = 1'b1;
    n = 0;
    while (!rx_locked_o && n < 3 * FRAME_W + LOOP_DELAY) begin
      @(negedge sys_clk);
      n++;
    end
    if (!rx_locked_o) begin
      $display("receiver did not lock on the training frames in time");
      end_with_failure();
    end
    repeat (4 * FRAME_W) @(negedge sys_clk);  // monitor flags any dv here
    check_bit("par_rdy_o", 1'b0, par_rdy_o);

    mon_mode = MON_USER;
    cfg_mode_i = MODE_USER;
    accepted = 0;
    low_run = 0;
    n = 0;
    // burst until the fifo holds user words only and ready stays low
    while (!(low_run >= 3 && exp_q.size() >= FIFO_DEPTH)) begin
      @(negedge sys_clk);
      rnd = $random(seed);
      par_dv_i = 1'b1;
      par_dat_i = rnd[15:0];
      if (par_rdy_o) begin
        exp_q.push_back(rnd[15:0]);
        accepted++;
        low_run = 0;
      end else begin
        low_run++;
      end
      n++;
      if (n > BURST_LIMIT) begin
        $display("par_rdy_o never stalled with the FIFO full of user words");
        end_with_failure();
      end
    end
    while (accepted < N_USER) begin  // random valid, some offers while not ready
      @(negedge sys_clk);
      rnd = $random(seed);
      par_dv_i = rnd[16];
      par_dat_i = rnd[15:0];
      if (par_dv_i && par_rdy_o) begin
        exp_q.push_back(rnd[15:0]);
        accepted++;
      end
    end
    @(negedge sys_clk);
    par_dv_i = 1'b0;
    while (exp_q.size() != 0) @(negedge sys_clk);
    cfg_mode_i = MODE_TRAIN;
    wait_quiet();

    rnd = $random(seed);
    cfg_custom_i = rnd[15:0];
    mon_mode = MON_CUSTOM;
    cfg_mode_i = MODE_CUSTOM;
    wait_rx(N_CUSTOM);
    cfg_mode_i = MODE_TRAIN;
    wait_quiet();  // custom words still in the fifo drain here

    chk_en_i = 1'b1;
    mon_mode = MON_RANDOM;
    cfg_mode_i = MODE_RANDOM;
    wait_rx(N_RANDOM);
    check_cnt("err_cnt_o", '0, err_cnt_o);

    // flip data bit pos of the frame two after the aligning dv pulse
    for (int f = 0; f < N_FLIP; f++) begin
      rnd = $random(seed);
      pos = 2 + int'(rnd[3:0]) % 14;  // frame bits 2..15, flag is bit 0
      wait_rx(1);
      repeat (11 + pos) @(negedge sys_clk);
      flip_en = 1'b1;
      flips_sent++;
      @(negedge sys_clk);
      flip_en = 1'b0;
      wait_rx(3);
    end
    if (bad_words != N_FLIP) begin
      $display("only %0d of %0d injected bit flips reached a received word",
               bad_words, N_FLIP);
      end_with_failure();
    end
    wait_rx(2);  // count holds over the following clean words
    check_cnt("err_cnt_o", err_cnt_t'(2 * N_FLIP), err_cnt_o);

    err_clr_i = 1'b1;
    @(negedge sys_clk);
    err_clr_i = 1'b0;
    check_cnt("err_cnt_o", '0, err_cnt_o);
    wait_rx(N_AFTER);
    check_cnt("err_cnt_o", '0, err_cnt_o);
    check_bit("rx_locked_o", 1'b1, rx_locked_o);

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* vlog.f */
rtl/daisy_pkg.sv
rtl/daisy_word_src.sv
rtl/daisy_tx_fifo.sv
rtl/daisy_serializer.sv
rtl/daisy_rx.sv
rtl/daisy_link.sv
verif/daisy_link_tb.sv

/* Makefile */
# Verilator flow for the daisy link, override any variable on the command line

VERILATOR ?= verilator
TOP       ?= daisy_link_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --timing --timescale 1ns/1ps -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q -- "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q -- "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
